/* sim.f */
+incdir+.
lsu_pkg.sv
lsu_ifs.sv
lsu_request_stage.sv
wb_data_master.sv
wb_data_ram.sv
lsu_writeback_stage.sv
lsu_top.sv
tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_lsu
./obj_dir/Vtb_lsu > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

/* tb_lsu_tests.svh */
// Reset state then fill words 0..15 and read one back
task automatic test_basic();
    check_bit("req_ready after reset", req_ready, 1'b1);
    check_bit("res_valid after reset", res_valid, 1'b0);
    for (int i = 0; i < 16; i++) begin
        send_req(lsu_pkg::LT_W, 1'b1, lsu_pkg::W_SEL_DLOAD, 32'(i * 4), $urandom(),
                 5'(i), '0);
        get_res();
    end
    send_req(lsu_pkg::LT_W, 1'b0, lsu_pkg::W_SEL_DLOAD, 32'h14, '0, 5'd7, '0);
    get_res();
endtask

// Word 3 rebuilt byte by byte and word 4 half by half before every load width
task automatic test_lanes();
    int step;

    for (int off = 0; off < 4; off++) begin
        send_req(lsu_pkg::LT_B, 1'b1, lsu_pkg::W_SEL_DLOAD, 32'(12 + off), $urandom(),
                 5'd0, '0);
        get_res();
    end
    for (int off = 0; off < 4; off += 2) begin
        send_req(lsu_pkg::LT_H, 1'b1, lsu_pkg::W_SEL_DLOAD, 32'(16 + off), $urandom(),
                 5'd0, '0);
        get_res();
    end
    for (int k = 0; k < 5; k++) begin
        if (lt_codes[k] == lsu_pkg::LT_W) begin
            step = 4;
        end else if (lt_codes[k] == lsu_pkg::LT_H || lt_codes[k] == lsu_pkg::LT_HU) begin
            step = 2;
        end else begin
            step = 1;
        end
        for (int off = 0; off < 4; off += step) begin
            send_req(lt_codes[k], 1'b0, lsu_pkg::W_SEL_DLOAD, 32'(12 + off), '0,
                     5'(k + 1), '0);
            get_res();
            send_req(lt_codes[k], 1'b0, lsu_pkg::W_SEL_DLOAD, 32'(16 + off), '0,
                     5'(k + 6), '0);
            get_res();
        end
    end
endtask

task automatic test_misaligned();
    send_req(lsu_pkg::LT_H, 1'b0, lsu_pkg::W_SEL_DLOAD, 32'h21, '0, 5'd3, '0);
    get_res();
    send_req(lsu_pkg::LT_W, 1'b0, lsu_pkg::W_SEL_DLOAD, 32'h22, '0, 5'd3, '0);
    get_res();
    send_req(lsu_pkg::LT_H, 1'b1, lsu_pkg::W_SEL_DLOAD, 32'h23, 32'hDEAD_BEEF, 5'd0, '0);
    get_res();
    send_req(lsu_pkg::LT_W, 1'b1, lsu_pkg::W_SEL_DLOAD, 32'h21, 32'h1234_5678, 5'd0, '0);
    get_res();
    // Word 8 still holds its fill value
    send_req(lsu_pkg::LT_W, 1'b0, lsu_pkg::W_SEL_DLOAD, 32'h20, '0, 5'd4, '0);
    get_res();
endtask

task automatic test_bus_error();
    send_req(lsu_pkg::LT_W, 1'b1, lsu_pkg::W_SEL_DLOAD, 32'h400, 32'hFFFF_FFFF, 5'd0, '0);
    get_res();
    send_req(lsu_pkg::LT_W, 1'b0, lsu_pkg::W_SEL_DLOAD, 32'h404, '0, 5'd9, '0);
    get_res();
    send_req(lsu_pkg::LT_B, 1'b0, lsu_pkg::W_SEL_DLOAD, 32'hFFFF_FFFD, '0, 5'd9, '0);
    get_res();
    // Word 0 would be hit if the index wrapped
    send_req(lsu_pkg::LT_W, 1'b0, lsu_pkg::W_SEL_DLOAD, 32'h0, '0, 5'd10, '0);
    get_res();
endtask

task automatic test_alu_pass();
    send_req(lsu_pkg::LT_W, 1'b0, lsu_pkg::W_SEL_ALU, 32'h8, '0, 5'd17, 32'hCAFE_0123);
    get_res();
    send_req(lsu_pkg::LT_W, 1'b0, lsu_pkg::W_SEL_ALU, 32'h10, '0, 5'd31, $urandom());
    get_res();
endtask

// Twelve random requests while results are collected in parallel
task automatic test_back_to_back();
    lsu_pkg::load_type_t  lt;
    logic                 store;
    lsu_pkg::w_sel_t      w_sel;

    stall_cycles = 0;
    fork
        begin
            for (int i = 0; i < 12; i++) begin
                store = ($urandom_range(0, 2) == 0);
                lt    = store ? lt_codes[$urandom_range(0, 2)] : lt_codes[$urandom_range(0, 4)];
                w_sel = store ? lsu_pkg::W_SEL_DLOAD : lsu_pkg::w_sel_t'($urandom_range(0, 3) == 0);
                send_req(lt, store, w_sel, 32'($urandom_range(0, 63)), $urandom(),
                         5'($urandom_range(1, 31)), $urandom());
            end
        end
        begin
            for (int i = 0; i < 12; i++) begin
                get_res();
            end
        end
    join
    check_bit("back-pressure seen during burst", stall_cycles > 0, 1'b1);
endtask

/* tb_lsu.sv */
`timescale 1ns/1ps

module tb_lsu;

    localparam int RAM_WORDS  = 256;
    localparam int WAIT_LIMIT = 50;

    logic                 CLK;
    logic                 nRST;
    logic                 req_valid;
    logic                 req_ready;
    logic                 req_store;
    lsu_pkg::load_type_t  req_load_type;
    lsu_pkg::w_sel_t      req_w_sel;
    lsu_pkg::word_t       req_addr;
    lsu_pkg::word_t       req_wdata;
    lsu_pkg::word_t       req_alu_result;
    lsu_pkg::reg_idx_t    req_rd;
    logic                 res_valid;
    logic                 res_reg_write;
    lsu_pkg::reg_idx_t    res_rd;
    lsu_pkg::word_t       res_data;
    lsu_pkg::fault_t      res_fault;

    // Reference copy of the data RAM
    lsu_pkg::word_t       ref_mem [RAM_WORDS];

    // Expected results, oldest first
    lsu_pkg::word_t       exp_data_q [$];
    lsu_pkg::reg_idx_t    exp_rd_q [$];
    lsu_pkg::fault_t      exp_fault_q [$];
    logic                 exp_we_q [$];
    logic                 exp_chk_q [$];

    // Byte, half and word codes first so stores can pick from 0..2
    lsu_pkg::load_type_t  lt_codes [5] = '{lsu_pkg::LT_B, lsu_pkg::LT_H, lsu_pkg::LT_W,
                                           lsu_pkg::LT_BU, lsu_pkg::LT_HU};

    int     errors;
    int     stall_cycles;
    int     seed_val;
    string  stop_reason;
    event   stop_run;

    lsu_top #(
        .RAM_WORDS (RAM_WORDS)
    ) dut0 (
        .CLK            (CLK),
        .nRST           (nRST),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_load_type  (req_load_type),
        .req_store      (req_store),
        .req_w_sel      (req_w_sel),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_rd         (req_rd),
        .req_alu_result (req_alu_result),
        .res_valid      (res_valid),
        .res_rd         (res_rd),
        .res_data       (res_data),
        .res_reg_write  (res_reg_write),
        .res_fault      (res_fault)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Ends the run when any wait expires
    initial begin
        @(stop_run);
        $display("%s", stop_reason);
        $display("Errors: %0d, run stopped by a timeout", errors);
        $display("Checks failed");
        $finish;
    end

    task automatic timeout_stop(input string what);
        stop_reason = what;
        -> stop_run;
        forever @(posedge CLK);
    endtask

    task automatic check_word(input string what, input lsu_pkg::word_t got,
                              input lsu_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_fault(input string what, input lsu_pkg::fault_t got,
                               input lsu_pkg::fault_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_rd(input string what, input lsu_pkg::reg_idx_t got,
                            input lsu_pkg::reg_idx_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Applies one access to the reference RAM and queues the expected result
    task automatic model_access(input lsu_pkg::load_type_t lt, input logic store,
                                input lsu_pkg::w_sel_t w_sel, input lsu_pkg::word_t addr,
                                input lsu_pkg::word_t wdata, input lsu_pkg::reg_idx_t rd,
                                input lsu_pkg::word_t alu);
        logic [1:0]       off;
        logic             mal;
        logic             we;
        int               idx;
        lsu_pkg::word_t   part;
        lsu_pkg::word_t   data;
        lsu_pkg::fault_t  fault;

        off   = addr[1:0];
        idx   = int'(addr[31:2]);
        data  = '0;
        we    = 1'b0;
        fault = lsu_pkg::FAULT_NONE;
        if (lt == lsu_pkg::LT_W) begin
            mal = (off != 2'b00);
        end else if (lt == lsu_pkg::LT_H || lt == lsu_pkg::LT_HU) begin
            mal = off[0];
        end else begin
            mal = 1'b0;
        end

        if (mal) begin
            fault = store ? lsu_pkg::FAULT_MAL_STORE : lsu_pkg::FAULT_MAL_LOAD;
        end else if ({2'b00, addr[31:2]} >= 32'(RAM_WORDS)) begin
            fault = lsu_pkg::FAULT_BUS;
        end else if (store) begin
            case (lt)
                lsu_pkg::LT_W:                 ref_mem[idx] = wdata;
                lsu_pkg::LT_H, lsu_pkg::LT_HU: ref_mem[idx][8*off +: 16] = wdata[15:0];
                default:                       ref_mem[idx][8*off +: 8] = wdata[7:0];
            endcase
        end else if (w_sel == lsu_pkg::W_SEL_ALU) begin
            data = alu;
            we   = 1'b1;
        end else begin
            we   = 1'b1;
            part = ref_mem[idx] >> (8 * off);
            case (lt)
                lsu_pkg::LT_B:  data = 32'($signed(part[7:0]));
                lsu_pkg::LT_BU: data = 32'(part[7:0]);
                lsu_pkg::LT_H:  data = 32'($signed(part[15:0]));
                lsu_pkg::LT_HU: data = 32'(part[15:0]);
                default:        data = part;
            endcase
        end

        exp_data_q.push_back(data);
        exp_rd_q.push_back(rd);
        exp_fault_q.push_back(fault);
        exp_we_q.push_back(we);
        // Data of a faulted load is left unchecked
        exp_chk_q.push_back(store || fault == lsu_pkg::FAULT_NONE);
    endtask

    // Called 2 ns after a rising edge and returns 2 ns after the transfer edge
    task automatic send_req(input lsu_pkg::load_type_t lt, input logic store,
                            input lsu_pkg::w_sel_t w_sel, input lsu_pkg::word_t addr,
                            input lsu_pkg::word_t wdata, input lsu_pkg::reg_idx_t rd,
                            input lsu_pkg::word_t alu);
        int n;

        model_access(lt, store, w_sel, addr, wdata, rd, alu);
        req_valid      = 1'b1;
        req_load_type  = lt;
        req_store      = store;
        req_w_sel      = w_sel;
        req_addr       = addr;
        req_wdata      = wdata;
        req_rd         = rd;
        req_alu_result = alu;
        n = 0;
        while (!req_ready) begin
            if (n == WAIT_LIMIT) begin
                timeout_stop("Timed out waiting for req_ready to accept a request.");
            end
            @(posedge CLK);
            #2;
            n++;
            stall_cycles++;
        end
        @(posedge CLK);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic get_res();
        int              n;
        lsu_pkg::word_t  exp;

        n = 0;
        while (!res_valid) begin
            if (n == WAIT_LIMIT) begin
                timeout_stop("Timed out waiting for res_valid.");
            end
            @(posedge CLK);
            #2;
            n++;
        end
        if (exp_data_q.size() == 0) begin
            errors++;
            $display("A result came out with no request outstanding.");
        end else begin
            check_rd("res_rd", res_rd, exp_rd_q.pop_front());
            check_fault("res_fault", res_fault, exp_fault_q.pop_front());
            check_bit("res_reg_write", res_reg_write, exp_we_q.pop_front());
            exp = exp_data_q.pop_front();
            if (exp_chk_q.pop_front()) begin
                check_word("res_data", res_data, exp);
            end
        end
        // Step past this pulse
        @(posedge CLK);
        #2;
    endtask

    `include "tb_lsu_tests.svh"

    initial begin
        seed_val       = $urandom(59);
        errors         = 0;
        stall_cycles   = 0;
        nRST           = 1'b0;
        req_valid      = 1'b0;
        req_load_type  = lsu_pkg::LT_W;
        req_store      = 1'b0;
        req_w_sel      = lsu_pkg::W_SEL_DLOAD;
        req_addr       = '0;
        req_wdata      = '0;
        req_rd         = '0;
        req_alu_result = '0;
        repeat (8) @(posedge CLK);
        #2;
        nRST = 1'b1;

        test_basic();
        test_lanes();
        test_misaligned();
        test_bus_error();
        test_alu_pass();
        test_back_to_back();

        if (exp_data_q.size() != 0) begin
            errors++;
            $display("%0d requests never produced a result.", exp_data_q.size());
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
    parameter int RAM_WORDS = 256
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  lsu_pkg::load_type_t  req_load_type,
    input  logic                 req_store,
    input  lsu_pkg::w_sel_t      req_w_sel,
    input  lsu_pkg::word_t       req_addr,
    input  lsu_pkg::word_t       req_wdata,
    input  lsu_pkg::reg_idx_t    req_rd,
    input  lsu_pkg::word_t       req_alu_result,
    output logic                 res_valid,
    output lsu_pkg::reg_idx_t    res_rd,
    output lsu_pkg::word_t       res_data,
    output logic                 res_reg_write,
    output lsu_pkg::fault_t      res_fault
);

    lsu_req_if  req_link ();
    lsu_rsp_if  rsp_link ();
    wb_bus_if   wb ();

    lsu_request_stage u_req (
        .CLK            (CLK),
        .nRST           (nRST),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_load_type  (req_load_type),
        .req_store      (req_store),
        .req_w_sel      (req_w_sel),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_rd         (req_rd),
        .req_alu_result (req_alu_result),
        .out_if         (req_link.src)
    );

    wb_data_master u_master (
        .CLK    (CLK),
        .nRST   (nRST),
        .in_if  (req_link.dst),
        .bus    (wb.master),
        .out_if (rsp_link.src)
    );

    wb_data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (wb.slave)
    );

    lsu_writeback_stage u_wb (
        .CLK           (CLK),
        .nRST          (nRST),
        .in_if         (rsp_link.dst),
        .res_valid     (res_valid),
        .res_rd        (res_rd),
        .res_data      (res_data),
        .res_reg_write (res_reg_write),
        .res_fault     (res_fault)
    );

endmodule

/* lsu_writeback_stage.sv */
`timescale 1ns/1ps

module lsu_writeback_stage (
    input  logic               CLK,
    input  logic               nRST,
    lsu_rsp_if.dst             in_if,
    output logic               res_valid,
    output lsu_pkg::reg_idx_t  res_rd,
    output lsu_pkg::word_t     res_data,
    output logic               res_reg_write,
    output lsu_pkg::fault_t    res_fault
);

    lsu_pkg::word_t  shifted;
    lsu_pkg::word_t  ext;
    lsu_pkg::word_t  sel_data;
    logic            reg_write;

    // Addressed byte or half down to bit 0
    assign shifted = in_if.rdata >> {in_if.byte_offset, 3'b000};

    always_comb begin
        case (in_if.load_type)
            lsu_pkg::LT_B:  ext = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LT_BU: ext = {24'h0, shifted[7:0]};
            lsu_pkg::LT_H:  ext = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LT_HU: ext = {16'h0, shifted[15:0]};
            default:        ext = in_if.rdata;
        endcase
    end

    always_comb begin
        if (in_if.store) begin
            sel_data = '0;
        end else if (in_if.w_sel == lsu_pkg::W_SEL_ALU) begin
            sel_data = in_if.alu_result;
        end else begin
            sel_data = ext;
        end
    end

    // Loads and pass-through results write back, stores never
    assign reg_write = !in_if.store && (in_if.fault == lsu_pkg::FAULT_NONE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            res_valid     <= 1'b0;
            res_reg_write <= 1'b0;
        end else begin
            res_valid     <= in_if.valid;
            res_reg_write <= in_if.valid && reg_write;
        end
    end

    always_ff @(posedge CLK) begin
        if (in_if.valid) begin
            res_rd    <= in_if.rd;
            res_data  <= sel_data;
            res_fault <= in_if.fault;
        end
    end

endmodule

/* wb_data_ram.sv */
`timescale 1ns/1ps

module wb_data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic     CLK,
    input  logic     nRST,
    wb_bus_if.slave  bus
);

    localparam int IDX_BITS = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    lsu_pkg::word_t       mem [RAM_WORDS];
    logic [IDX_BITS-1:0]  idx;
    logic                 in_range;
    logic                 start;

    // Word index from the byte address
    assign idx      = bus.adr[IDX_BITS+1:2];
    assign in_range = {2'b00, bus.adr[31:2]} < lsu_pkg::word_t'(RAM_WORDS);

    // A new strobe only and not the one still held during ack
    assign start = bus.cyc && bus.stb && !bus.ack && !bus.err;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            bus.ack <= 1'b0;
            bus.err <= 1'b0;
        end else begin
            bus.ack <= start && in_range;
            bus.err <= start && !in_range;
        end
    end

    always_ff @(posedge CLK) begin
        if (start && in_range) begin
            if (bus.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.sel[i]) begin
                        mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
                    end
                end
            end
            bus.dat_r <= mem[idx];
        end else if (start) begin
            bus.dat_r <= '0;
        end
    end

    // Master strobes only inside a cycle
    a_stb_in_cyc: assert property (@(posedge CLK) disable iff (!nRST)
        bus.stb |-> bus.cyc);

    // Master closes the cycle right after ack or err
    a_cyc_drop: assert property (@(posedge CLK) disable iff (!nRST)
        bus.cyc && (bus.ack || bus.err) |=> !bus.cyc);

endmodule

/* wb_data_master.sv */
`timescale 1ns/1ps

module wb_data_master (
    input  logic      CLK,
    input  logic      nRST,
    lsu_req_if.dst    in_if,
    wb_bus_if.master  bus,
    lsu_rsp_if.src    out_if
);

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_CYCLE,
        WB_RESP
    } wb_state_e;

    wb_state_e            state;
    wb_state_e            state_n;
    logic                 done;

    lsu_pkg::word_t       addr_q;
    lsu_pkg::byte_en_t    sel_q;
    lsu_pkg::word_t       wdata_q;
    logic                 store_q;
    lsu_pkg::load_type_t  load_type_q;
    lsu_pkg::w_sel_t      w_sel_q;
    lsu_pkg::reg_idx_t    rd_q;
    lsu_pkg::word_t       alu_q;
    lsu_pkg::fault_t      fault_q;
    lsu_pkg::word_t       rdata_q;

    assign in_if.ready = (state == WB_IDLE);
    assign done        = bus.ack || bus.err;

    always_comb begin
        state_n = state;
        case (state)
            WB_IDLE: begin
                // Faulted requests bypass the bus
                if (in_if.valid) begin
                    state_n = (in_if.fault != lsu_pkg::FAULT_NONE) ? WB_RESP : WB_CYCLE;
                end
            end
            WB_CYCLE: begin
                if (done) begin
                    state_n = WB_RESP;
                end
            end
            default: state_n = WB_IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= WB_IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == WB_IDLE && in_if.valid) begin
            addr_q      <= in_if.addr;
            sel_q       <= in_if.byte_en;
            wdata_q     <= in_if.wdata;
            store_q     <= in_if.store;
            load_type_q <= in_if.load_type;
            w_sel_q     <= in_if.w_sel;
            rd_q        <= in_if.rd;
            alu_q       <= in_if.alu_result;
            fault_q     <= in_if.fault;
        end else if (state == WB_CYCLE && done) begin
            rdata_q <= bus.dat_r;
            if (bus.err) begin
                fault_q <= lsu_pkg::FAULT_BUS;
            end
        end
    end

    assign bus.cyc   = (state == WB_CYCLE);
    assign bus.stb   = (state == WB_CYCLE);
    assign bus.we    = store_q;
    assign bus.adr   = addr_q;
    assign bus.sel   = sel_q;
    assign bus.dat_w = wdata_q;

    assign out_if.valid       = (state == WB_RESP);
    assign out_if.rdata       = rdata_q;
    assign out_if.byte_offset = addr_q[1:0];
    assign out_if.load_type   = load_type_q;
    assign out_if.w_sel       = w_sel_q;
    assign out_if.rd          = rd_q;
    assign out_if.alu_result  = alu_q;
    assign out_if.store       = store_q;
    assign out_if.fault       = fault_q;

    // Held request must not change until it is taken
    a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        in_if.valid && !in_if.ready |=> in_if.valid && $stable(in_if.addr)
            && $stable(in_if.wdata) && $stable(in_if.byte_en) && $stable(in_if.rd)
            && $stable(in_if.fault));

    // Slave ends a cycle with either ack or err
    a_ack_err_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(bus.ack && bus.err));

endmodule

/* lsu_request_stage.sv */
`timescale 1ns/1ps

module lsu_request_stage (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  lsu_pkg::load_type_t  req_load_type,
    input  logic                 req_store,
    input  lsu_pkg::w_sel_t      req_w_sel,
    input  lsu_pkg::word_t       req_addr,
    input  lsu_pkg::word_t       req_wdata,
    input  lsu_pkg::reg_idx_t    req_rd,
    input  lsu_pkg::word_t       req_alu_result,
    lsu_req_if.src               out_if
);

    lsu_pkg::byte_en_t    byte_en;
    lsu_pkg::word_t       lanes;
    lsu_pkg::fault_t      fault;
    logic                 mal;
    logic                 take;
    logic                 full;

    lsu_pkg::word_t       addr_q;
    lsu_pkg::byte_en_t    byte_en_q;
    lsu_pkg::word_t       wdata_q;
    logic                 store_q;
    lsu_pkg::load_type_t  load_type_q;
    lsu_pkg::w_sel_t      w_sel_q;
    lsu_pkg::reg_idx_t    rd_q;
    lsu_pkg::word_t       alu_q;
    lsu_pkg::fault_t      fault_q;

    // Lane decode and store replication by access width
    always_comb begin
        mal = 1'b0;
        case (req_load_type)
            lsu_pkg::LT_B, lsu_pkg::LT_BU: begin
                byte_en = 4'b0001 << req_addr[1:0];
                lanes   = {4{req_wdata[7:0]}};
            end
            lsu_pkg::LT_H, lsu_pkg::LT_HU: begin
                byte_en = req_addr[1] ? 4'b1100 : 4'b0011;
                lanes   = {2{req_wdata[15:0]}};
                mal     = req_addr[0];
            end
            default: begin
                byte_en = 4'b1111;
                lanes   = req_wdata;
                mal     = req_addr[1:0] != 2'b00;
            end
        endcase
        // No lanes for a misaligned access
        if (mal) begin
            byte_en = '0;
        end
    end

    assign fault = !mal ? lsu_pkg::FAULT_NONE :
                   req_store ? lsu_pkg::FAULT_MAL_STORE : lsu_pkg::FAULT_MAL_LOAD;

    // Room when empty or when the master takes the held item this cycle
    assign req_ready = !full || out_if.ready;
    assign take      = req_valid && req_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (out_if.ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            addr_q      <= req_addr;
            byte_en_q   <= byte_en;
            wdata_q     <= lanes;
            store_q     <= req_store;
            load_type_q <= req_load_type;
            w_sel_q     <= req_w_sel;
            rd_q        <= req_rd;
            alu_q       <= req_alu_result;
            fault_q     <= fault;
        end
    end

    assign out_if.valid      = full;
    assign out_if.addr       = addr_q;
    assign out_if.byte_en    = byte_en_q;
    assign out_if.wdata      = wdata_q;
    assign out_if.store      = store_q;
    assign out_if.load_type  = load_type_q;
    assign out_if.w_sel      = w_sel_q;
    assign out_if.rd         = rd_q;
    assign out_if.alu_result = alu_q;
    assign out_if.fault      = fault_q;

endmodule

/* lsu_ifs.sv */
`timescale 1ns/1ps

// Registered request toward the bus master
interface lsu_req_if;
    logic                 valid;
    logic                 ready;
    lsu_pkg::word_t       addr;
    lsu_pkg::byte_en_t    byte_en;
    lsu_pkg::word_t       wdata;
    logic                 store;
    lsu_pkg::load_type_t  load_type;
    lsu_pkg::w_sel_t      w_sel;
    lsu_pkg::reg_idx_t    rd;
    lsu_pkg::word_t       alu_result;
    lsu_pkg::fault_t      fault;

    modport src (output valid, addr, byte_en, wdata, store, load_type, w_sel, rd,
                 alu_result, fault, input ready);
    modport dst (input valid, addr, byte_en, wdata, store, load_type, w_sel, rd,
                 alu_result, fault, output ready);
endinterface

// Raw access result, one-cycle valid pulse
interface lsu_rsp_if;
    logic                 valid;
    lsu_pkg::word_t       rdata;
    logic [1:0]           byte_offset;
    lsu_pkg::load_type_t  load_type;
    lsu_pkg::w_sel_t      w_sel;
    lsu_pkg::reg_idx_t    rd;
    lsu_pkg::word_t       alu_result;
    logic                 store;
    lsu_pkg::fault_t      fault;

    modport src (output valid, rdata, byte_offset, load_type, w_sel, rd, alu_result,
                 store, fault);
    modport dst (input valid, rdata, byte_offset, load_type, w_sel, rd, alu_result,
                 store, fault);
endinterface

// Wishbone classic, little-endian
interface wb_bus_if;
    logic               cyc;
    logic               stb;
    logic               we;
    lsu_pkg::word_t     adr;
    lsu_pkg::byte_en_t  sel;
    lsu_pkg::word_t     dat_w;
    lsu_pkg::word_t     dat_r;
    logic               ack;
    logic               err;

    modport master (output cyc, stb, we, adr, sel, dat_w, input dat_r, ack, err);
    modport slave  (input cyc, stb, we, adr, sel, dat_w, output dat_r, ack, err);
endinterface

/* lsu_pkg.sv */
package lsu_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // One bit per byte lane of a word
    typedef logic [3:0] byte_en_t;

    // Destination register index
    typedef logic [4:0] reg_idx_t;

    // Access width and sign, encoded as in funct3
    typedef logic [2:0] load_type_t;

    localparam load_type_t LT_B  = 3'b000;
    localparam load_type_t LT_H  = 3'b001;
    localparam load_type_t LT_W  = 3'b010;
    localparam load_type_t LT_BU = 3'b100;
    localparam load_type_t LT_HU = 3'b101;

    // Source of the register write-back value
    typedef logic w_sel_t;

    localparam w_sel_t W_SEL_DLOAD = 1'b0;
    localparam w_sel_t W_SEL_ALU   = 1'b1;

    // Result status
    typedef logic [1:0] fault_t;

    localparam fault_t FAULT_NONE      = 2'd0;
    localparam fault_t FAULT_MAL_LOAD  = 2'd1;
    localparam fault_t FAULT_MAL_STORE = 2'd2;
    localparam fault_t FAULT_BUS       = 2'd3;

endpackage
